//--- tb.f
+incdir+include
rtl/core_pkg.sv
rtl/alu.sv
rtl/rs_entry.sv
rtl/rs_dispatch.sv
rtl/rs_issue.sv
rtl/exec_cluster.sv
tests/tb_exec_cluster.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/alu.sv
      - rtl/rs_entry.sv
      - rtl/rs_dispatch.sv
      - rtl/rs_issue.sv
      - rtl/exec_cluster.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_exec_cluster.sv

//--- include/exec_ref_model.svh
/* reference model of ALU results and jump targets
   included inside the testbench module */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// expected broadcast value
function automatic logic [31:0] alu_value_model(core_pkg::alu_op_e op, logic [31:0] a,
                                                logic [31:0] b, logic [31:0] pc,
                                                logic [31:0] imm);
  logic [31:0] v;
  case (op)
    core_pkg::ADD:   v = a + b;
    core_pkg::SUB:   v = a - b;
    core_pkg::AND:   v = a & b;
    core_pkg::OR:    v = a | b;
    core_pkg::XOR:   v = a ^ b;
    core_pkg::SLL:   v = a << b[4:0];
    core_pkg::SRL:   v = a >> b[4:0];
    core_pkg::SRA:   v = $unsigned($signed(a) >>> b[4:0]);
    core_pkg::SLT:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    core_pkg::SLTU:  v = (a < b) ? 32'd1 : 32'd0;
    core_pkg::BEQ:   v = (a == b) ? 32'd1 : 32'd0;
    core_pkg::BNE:   v = (a != b) ? 32'd1 : 32'd0;
    core_pkg::BLT:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    core_pkg::BGE:   v = ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
    core_pkg::BLTU:  v = (a < b) ? 32'd1 : 32'd0;
    core_pkg::BGEU:  v = (a >= b) ? 32'd1 : 32'd0;
    core_pkg::JAL,
    core_pkg::JALR:  v = pc + 32'd4;
    core_pkg::LUI:   v = imm;
    core_pkg::AUIPC: v = pc + imm;
    default:         v = 32'd0;
  endcase
  return v;
endfunction

// expected jump target or zero for non-control-flow ops
function automatic logic [31:0] jump_pc_model(core_pkg::alu_op_e op, logic [31:0] a,
                                              logic [31:0] b, logic [31:0] pc,
                                              logic [31:0] imm);
  logic [31:0] cond;
  logic [31:0] t;
  cond = alu_value_model(op, a, b, pc, imm);
  case (op)
    core_pkg::BEQ, core_pkg::BNE, core_pkg::BLT,
    core_pkg::BGE, core_pkg::BLTU, core_pkg::BGEU:
      t = cond[0] ? pc + imm : pc + 32'd4;
    core_pkg::JAL:  t = pc + imm;
    core_pkg::JALR: t = (a + imm) & ~32'd1;
    default:        t = 32'd0;
  endcase
  return t;
endfunction

`endif

//--- tests/tb_exec_cluster.sv
/* testbench for the execution cluster checking random ops against a tag scoreboard
   compile with tb.f and run top module tb_exec_cluster */
`timescale 1ns/1ps

module tb_exec_cluster import core_pkg::*; ();

  localparam int RS_SIZE        = 4;
  localparam int NUM_TAGS       = 1 << ROB_TAG_W;
  localparam int NUM_OPS        = 200;
  localparam int TIMEOUT_CYCLES = 30 * NUM_OPS + 200;

  typedef enum logic [1:0] {TAG_FREE, TAG_PEND, TAG_EXT, TAG_DONE} tag_state_e;

  logic            clk_in;
  logic            reset;
  logic            rdy_in;
  logic            jump_wrong;
  logic            dispatch_valid;
  rs_op_t          dispatch_op;
  cdb_t            ext_cdb;
  logic            rs_full;
  cdb_t            alu_cdb;
  logic [XLEN-1:0] alu_jump_pc;

  // scoreboard with one record per tag
  tag_state_e      tag_state [NUM_TAGS];
  logic [XLEN-1:0] tag_value [NUM_TAGS];
  bit              accepted  [NUM_TAGS];
  rs_op_t          op_rec    [NUM_TAGS];

  int held_tag = -1;
  int created;
  int inflight;
  int flushes;
  int same_cycle_ext;
  int cycles;
  int freeze_left;
  bit run_active;
  bit saw_full;

  `include "exec_ref_model.svh"

  exec_cluster #(.RS_SIZE(RS_SIZE)) i_dut (.*);

  task automatic raise_error(string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(logic [XLEN-1:0] actual, logic [XLEN-1:0] expected, string what);
    if (actual !== expected) begin
      raise_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  function automatic int count_state(tag_state_e s);
    int n;
    n = 0;
    for (int u = 0; u < NUM_TAGS; u++) begin
      if (tag_state[u] == s) n++;
    end
    return n;
  endfunction

  function automatic bit all_done();
    return created >= NUM_OPS && held_tag < 0 &&
           count_state(TAG_PEND) == 0 && count_state(TAG_EXT) == 0;
  endfunction

  // immediate, value of a broadcast tag, or an outstanding tag to wait on
  function automatic operand_t make_source();
    operand_t s;
    int       pool[$];
    int       kind;
    int       t;
    s.valid = 1'b1;
    s.tag   = '0;
    s.value = $urandom_range(0, 1) ? $urandom : $urandom_range(0, 3);
    kind = (created < 20) ? 0 : $urandom_range(0, 2);
    // back-pressure window mostly waits on slow external tags
    if (created >= 40 && created < 60) kind = ($urandom_range(0, 3) == 0) ? 0 : 2;
    for (int u = 0; u < NUM_TAGS; u++) begin
      if ((kind == 1 && tag_state[u] == TAG_DONE) ||
          (kind == 2 && (tag_state[u] == TAG_EXT ||
                         (tag_state[u] == TAG_PEND && accepted[u])))) begin
        pool.push_back(u);
      end
    end
    if (kind != 0 && pool.size() > 0) begin
      t = pool[$urandom_range(0, pool.size() - 1)];
      if (kind == 1) begin
        s.value = tag_value[t];
      end else begin
        s.valid = 1'b0;
        s.tag   = rob_tag_t'(t);
        s.value = '0;
      end
    end
    return s;
  endfunction

  task automatic create_op();
    int free_q[$];
    int idx;
    int t;
    for (int u = 0; u < NUM_TAGS; u++) begin
      if (tag_state[u] == TAG_FREE || tag_state[u] == TAG_DONE) free_q.push_back(u);
    end
    if (free_q.size() < 2) return;
    // reserve a tag whose result arrives on ext_cdb
    if (created >= 20 && count_state(TAG_EXT) < 3 && $urandom_range(0, 2) == 0) begin
      idx = $urandom_range(0, free_q.size() - 1);
      t   = free_q[idx];
      free_q.delete(idx);
      tag_state[t] = TAG_EXT;
      tag_value[t] = $urandom;
    end
    t = free_q[$urandom_range(0, free_q.size() - 1)];
    // first ops walk through every opcode
    op_rec[t].op   = (created < 20) ? alu_op_e'(created) : alu_op_e'($urandom_range(0, 19));
    op_rec[t].dest = rob_tag_t'(t);
    op_rec[t].pc   = $urandom & 32'hffff_fffc;
    op_rec[t].imm  = $urandom_range(0, 4095) - 2048;
    op_rec[t].src1 = make_source();
    op_rec[t].src2 = make_source();
    tag_state[t] = TAG_PEND;
    accepted[t]  = 1'b0;
    held_tag     = t;
    created++;
  endtask

  task automatic drive_cycle();
    int ext_q[$];
    int t;
    int ext_odds;
    bit flush;
    ext_cdb = '0;
    if (freeze_left > 0) begin
      freeze_left--;
    end else if (created >= 60 && created < NUM_OPS && $urandom_range(0, 11) == 0) begin
      freeze_left = $urandom_range(1, 5);
    end
    rdy_in = (freeze_left == 0);
    flush  = rdy_in && created >= 100 && created < NUM_OPS &&
             ($urandom_range(0, 39) == 0 || (flushes == 0 && created >= 150));
    jump_wrong = flush;
    if (held_tag < 0 && created < NUM_OPS && !flush) create_op();
    dispatch_valid = (held_tag >= 0);
    if (held_tag >= 0) begin
      dispatch_op = op_rec[held_tag];
    end else begin
      dispatch_op = '0;
    end
    for (int u = 0; u < NUM_TAGS; u++) begin
      if (tag_state[u] == TAG_EXT) ext_q.push_back(u);
    end
    ext_odds = (created >= NUM_OPS) ? 1 : (created >= 40 && created < 60) ? 16 : 4;
    if (rdy_in && !flush && ext_q.size() > 0) begin
      t = ext_q[$urandom_range(0, ext_q.size() - 1)];
      // hit the source of an op in its own dispatch cycle
      if (held_tag >= 0 && !rs_full && !op_rec[held_tag].src1.valid &&
          tag_state[op_rec[held_tag].src1.tag] == TAG_EXT && $urandom_range(0, 3) == 0) begin
        t        = op_rec[held_tag].src1.tag;
        ext_odds = 1;
      end
      if ($urandom_range(1, ext_odds) == 1) begin
        ext_cdb.valid = 1'b1;
        ext_cdb.tag   = rob_tag_t'(t);
        ext_cdb.value = tag_value[t];
      end
    end
  endtask

  task automatic wake_waiters(int t, logic [XLEN-1:0] v);
    for (int u = 0; u < NUM_TAGS; u++) begin
      if (tag_state[u] == TAG_PEND) begin
        if (!op_rec[u].src1.valid && op_rec[u].src1.tag == t) begin
          op_rec[u].src1.valid = 1'b1;
          op_rec[u].src1.value = v;
        end
        if (!op_rec[u].src2.valid && op_rec[u].src2.tag == t) begin
          op_rec[u].src2.valid = 1'b1;
          op_rec[u].src2.value = v;
        end
      end
    end
  endtask

  task automatic take_alu_broadcast();
    int              t;
    rs_op_t          r;
    logic [XLEN-1:0] exp_value;
    logic [XLEN-1:0] exp_jump;
    t = int'(alu_cdb.tag);
    r = op_rec[t];
    if (tag_state[t] != TAG_PEND || !accepted[t]) begin
      raise_error($sformatf("tag %0d was broadcast at %0t but is not outstanding", t, $time));
    end
    if (!r.src1.valid || !r.src2.valid) begin
      raise_error($sformatf("tag %0d was broadcast at %0t before its sources", t, $time));
    end
    exp_value = alu_value_model(r.op, r.src1.value, r.src2.value, r.pc, r.imm);
    exp_jump  = jump_pc_model(r.op, r.src1.value, r.src2.value, r.pc, r.imm);
    check_equal(alu_cdb.value, exp_value, $sformatf("value of tag %0d (%s)", t, r.op.name()));
    check_equal(alu_jump_pc, exp_jump, $sformatf("jump_pc of tag %0d (%s)", t, r.op.name()));
    tag_state[t] = TAG_DONE;
    tag_value[t] = exp_value;
    wake_waiters(t, exp_value);
    inflight--;
  endtask

  task automatic sample_cycle();
    bit exp_full;
    int t;
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      raise_error($sformatf("timeout after %0d cycles with %0d ops created", cycles, created));
    end
    // the op shown on alu_cdb has left its slot but is still in flight
    exp_full = (inflight - int'(alu_cdb.valid)) == RS_SIZE;
    check_equal(32'(rs_full), 32'(exp_full), "rs_full");
    if (rs_full) saw_full = 1'b1;
    if (!rdy_in) return;
    if (alu_cdb.valid) take_alu_broadcast();
    if (ext_cdb.valid) begin
      t = int'(ext_cdb.tag);
      tag_state[t] = TAG_DONE;
      wake_waiters(t, ext_cdb.value);
    end
    if (jump_wrong) begin
      for (int u = 0; u < NUM_TAGS; u++) begin
        if (tag_state[u] == TAG_PEND || tag_state[u] == TAG_EXT) tag_state[u] = TAG_FREE;
        accepted[u] = 1'b0;
      end
      held_tag = -1;
      inflight = 0;
      flushes++;
    end else if (dispatch_valid && !rs_full) begin
      if (ext_cdb.valid && !dispatch_op.src1.valid && dispatch_op.src1.tag == ext_cdb.tag) begin
        same_cycle_ext++;
      end
      accepted[held_tag] = 1'b1;
      held_tag = -1;
      inflight++;
    end
  endtask

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  always @(negedge clk_in) begin
    if (run_active) sample_cycle();
  end

  initial begin
    void'($urandom(32'h4e90_c7e8));
    reset          = 1'b1;
    rdy_in         = 1'b1;
    jump_wrong     = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_op    = '0;
    ext_cdb        = '0;
    for (int u = 0; u < NUM_TAGS; u++) begin
      tag_state[u] = TAG_FREE;
      tag_value[u] = '0;
      accepted[u]  = 1'b0;
    end
    repeat (4) @(posedge clk_in);
    #2;
    reset      = 1'b0;
    run_active = 1'b1;
    while (!all_done()) begin
      drive_cycle();
      @(posedge clk_in);
      #2;
    end
    // idle tail where a stray broadcast still fails
    rdy_in         = 1'b1;
    jump_wrong     = 1'b0;
    dispatch_valid = 1'b0;
    ext_cdb        = '0;
    repeat (5) @(posedge clk_in);
    if (!saw_full || flushes == 0 || same_cycle_ext == 0) begin
      raise_error($sformatf("stimulus missed a case: rs_full seen %0b, flushes %0d, ext hits %0d",
                            saw_full, flushes, same_cycle_ext));
    end else begin
      $display("%0d operations done in %0d cycles, %0d flushes", created, cycles, flushes);
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- rtl/exec_cluster.sv
/* out-of-order execution cluster with reservation station slots and ALU
   takes dispatched ops and broadcasts results on alu_cdb */
`timescale 1ns/1ps

module exec_cluster import core_pkg::*; #(
  parameter int RS_SIZE = 4
) (
  input  logic            clk_in,
  input  logic            reset,
  input  logic            rdy_in,
  input  logic            jump_wrong,
  input  logic            dispatch_valid,
  input  rs_op_t          dispatch_op,
  input  cdb_t            ext_cdb,
  output logic            rs_full,
  output cdb_t            alu_cdb,
  output logic [XLEN-1:0] alu_jump_pc
);

  logic [RS_SIZE-1:0] write;
  logic [RS_SIZE-1:0] issue;
  logic [RS_SIZE-1:0] busy;
  logic [RS_SIZE-1:0] ready;
  rs_op_t             write_op;
  rs_op_t             slot_op [RS_SIZE];

  rs_dispatch #(.RS_SIZE(RS_SIZE)) rs_dispatch_ (
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .rdy_in         (rdy_in),
    .jump_wrong     (jump_wrong),
    .busy           (busy),
    .alu_cdb        (alu_cdb),
    .ext_cdb        (ext_cdb),
    .write          (write),
    .write_op       (write_op),
    .rs_full        (rs_full)
  );

  for (genvar i = 0; i < RS_SIZE; i++) begin : g_slot
    rs_entry rs_entry_ (
      .clk_in     (clk_in),
      .reset      (reset),
      .rdy_in     (rdy_in),
      .jump_wrong (jump_wrong),
      .write      (write[i]),
      .write_op   (write_op),
      .issue      (issue[i]),
      .alu_cdb    (alu_cdb),
      .ext_cdb    (ext_cdb),
      .busy       (busy[i]),
      .ready      (ready[i]),
      .op         (slot_op[i])
    );
  end

  rs_issue #(.RS_SIZE(RS_SIZE)) rs_issue_ (
    .clk_in      (clk_in),
    .reset       (reset),
    .rdy_in      (rdy_in),
    .jump_wrong  (jump_wrong),
    .ready       (ready),
    .slot_op     (slot_op),
    .issue       (issue),
    .alu_cdb     (alu_cdb),
    .alu_jump_pc (alu_jump_pc)
  );

endmodule

//--- rtl/rs_issue.sv
/* issue side of the reservation station
   grants the lowest ready slot, runs the ALU and registers the broadcast */
`timescale 1ns/1ps

module rs_issue import core_pkg::*; #(
  parameter int RS_SIZE = 4
) (
  input  logic               clk_in,
  input  logic               reset,
  input  logic               rdy_in,
  input  logic               jump_wrong,
  input  logic [RS_SIZE-1:0] ready,
  input  rs_op_t             slot_op [RS_SIZE],
  output logic [RS_SIZE-1:0] issue,
  output cdb_t               alu_cdb,
  output logic [XLEN-1:0]    alu_jump_pc
);

  localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

  logic             grant_en;
  logic             grant;
  logic [IDX_W-1:0] grant_idx;
  rs_op_t           sel_op;
  alu_result_t      alu_out;

  logic             cdb_valid;
  rob_tag_t         cdb_tag;
  logic [XLEN-1:0]  cdb_value;
  logic [XLEN-1:0]  jump_pc_q;

  assign grant_en = rdy_in && !jump_wrong;

  // lowest-index ready slot wins
  always_comb begin
    grant     = 1'b0;
    grant_idx = '0;
    issue     = '0;
    for (int i = 0; i < RS_SIZE; i++) begin
      if (grant_en && ready[i] && !grant) begin
        grant     = 1'b1;
        grant_idx = IDX_W'(i);
        issue[i]  = 1'b1;
      end
    end
  end

  assign sel_op = slot_op[grant_idx];

  alu alu_ (
    .op     (sel_op.op),
    .a      (sel_op.src1.value),
    .b      (sel_op.src2.value),
    .pc     (sel_op.pc),
    .imm    (sel_op.imm),
    .result (alu_out)
  );

  // broadcast strobe lasts one unfrozen cycle
  always_ff @(posedge clk_in) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else if (rdy_in) begin
      cdb_valid <= grant;
    end
  end

  always_ff @(posedge clk_in) begin
    if (grant) begin
      cdb_tag   <= sel_op.dest;
      cdb_value <= alu_out.result;
      jump_pc_q <= alu_out.jump_pc;
    end
  end

  assign alu_cdb.valid = cdb_valid;
  assign alu_cdb.tag   = cdb_tag;
  assign alu_cdb.value = cdb_value;
  assign alu_jump_pc   = jump_pc_q;

endmodule

//--- rtl/rs_dispatch.sv
/* dispatch side of the reservation station
   picks the lowest free slot and forwards same-cycle broadcasts */
`timescale 1ns/1ps

module rs_dispatch import core_pkg::*; #(
  parameter int RS_SIZE = 4
) (
  input  logic               dispatch_valid,
  input  rs_op_t             dispatch_op,
  input  logic               rdy_in,
  input  logic               jump_wrong,
  input  logic [RS_SIZE-1:0] busy,
  input  cdb_t               alu_cdb,
  input  cdb_t               ext_cdb,
  output logic [RS_SIZE-1:0] write,
  output rs_op_t             write_op,
  output logic               rs_full
);

  logic accept;
  logic found;

  assign rs_full = &busy;
  assign accept  = dispatch_valid && !rs_full && rdy_in && !jump_wrong;

  // one-hot strobe on the lowest free slot
  always_comb begin
    write = '0;
    found = 1'b0;
    for (int i = 0; i < RS_SIZE; i++) begin
      if (accept && !busy[i] && !found) begin
        write[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  // a tag broadcast in the dispatch cycle would be missed by the slot
  always_comb begin
    write_op      = dispatch_op;
    write_op.src1 = resolve_operand(dispatch_op.src1, alu_cdb, ext_cdb);
    write_op.src2 = resolve_operand(dispatch_op.src2, alu_cdb, ext_cdb);
  end

endmodule

//--- rtl/rs_entry.sv
/* one reservation-station slot, woken by the ALU and external broadcasts
   loaded by dispatch and freed by issue */
`timescale 1ns/1ps

module rs_entry import core_pkg::*; (
  input  logic   clk_in,
  input  logic   reset,
  input  logic   rdy_in,
  input  logic   jump_wrong,
  input  logic   write,
  input  rs_op_t write_op,
  input  logic   issue,
  input  cdb_t   alu_cdb,
  input  cdb_t   ext_cdb,
  output logic   busy,
  output logic   ready,
  output rs_op_t op
);

  operand_t src1_next;
  operand_t src2_next;

  assign src1_next = resolve_operand(op.src1, alu_cdb, ext_cdb);
  assign src2_next = resolve_operand(op.src2, alu_cdb, ext_cdb);

  // occupancy
  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (rdy_in) begin
      if (jump_wrong) begin
        busy <= 1'b0;
      end else if (write) begin
        busy <= 1'b1;
      end else if (issue) begin
        busy <= 1'b0;
      end
    end
  end

  // held operation and operand wake-up
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (write) begin
        op <= write_op;
      end else begin
        op.src1 <= src1_next;
        op.src2 <= src2_next;
      end
    end
  end

  // wake-up is registered, so a woken slot issues one cycle later
  assign ready = busy && op.src1.valid && op.src2.valid;

endmodule

//--- rtl/alu.sv
/* combinational RV32I ALU for integer, branch and jump operations
   fed by the issue stage, result registered outside */
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  alu_op_e         op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] imm,
  output alu_result_t     result
);

  logic [XLEN-1:0] pc_plus_4;
  logic [XLEN-1:0] pc_plus_imm;
  logic [XLEN-1:0] jalr_target;
  logic [4:0]      shamt;
  logic            taken;

  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + imm;
  assign jalr_target = (a + imm) & ~32'd1;
  assign shamt       = b[4:0];

  // branch condition
  always_comb begin
    case (op)
      BEQ:     taken = (a == b);
      BNE:     taken = (a != b);
      BLT:     taken = ($signed(a) < $signed(b));
      BGE:     taken = ($signed(a) >= $signed(b));
      BLTU:    taken = (a < b);
      BGEU:    taken = (a >= b);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    result.result  = '0;
    result.jump_pc = '0;
    case (op)
      ADD:   result.result = a + b;
      SUB:   result.result = a - b;
      AND:   result.result = a & b;
      OR:    result.result = a | b;
      XOR:   result.result = a ^ b;
      SLL:   result.result = a << shamt;
      SRL:   result.result = a >> shamt;
      SRA:   result.result = $unsigned($signed(a) >>> shamt);
      SLT:   result.result = {31'd0, $signed(a) < $signed(b)};
      SLTU:  result.result = {31'd0, a < b};
      LUI:   result.result = imm;
      AUIPC: result.result = pc_plus_imm;
      BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
        result.result  = {31'd0, taken};
        // not-taken branches resume at the next instruction
        result.jump_pc = taken ? pc_plus_imm : pc_plus_4;
      end
      JAL: begin
        result.result  = pc_plus_4;
        result.jump_pc = pc_plus_imm;
      end
      JALR: begin
        result.result  = pc_plus_4;
        result.jump_pc = jalr_target;
      end
      default: result.result = '0;
    endcase
  end

endmodule

//--- rtl/core_pkg.sv
/* shared widths, opcodes and bus structs for the execution cluster
   imported by every RTL module and by the testbench */
package core_pkg;

  localparam int XLEN      = 32;
  localparam int ROB_TAG_W = 4;

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // integer, branch and jump operations handled by the ALU
  typedef enum logic [4:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA, SLT, SLTU,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    JAL, JALR, LUI, AUIPC
  } alu_op_e;

  // source operand holding a value or the tag it waits on
  typedef struct packed {
    logic            valid;
    rob_tag_t        tag;
    logic [XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    alu_op_e         op;
    rob_tag_t        dest;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    operand_t        src1;
    operand_t        src2;
  } rs_op_t;

  // one result broadcast on a common data bus
  typedef struct packed {
    logic            valid;
    rob_tag_t        tag;
    logic [XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] jump_pc;
  } alu_result_t;

  // pick up a waiting operand's value from either broadcast bus
  function automatic operand_t resolve_operand(operand_t src, cdb_t alu_bus, cdb_t ext_bus);
    operand_t res;
    res = src;
    if (!src.valid) begin
      if (alu_bus.valid && alu_bus.tag == src.tag) begin
        res.valid = 1'b1;
        res.value = alu_bus.value;
      end else if (ext_bus.valid && ext_bus.tag == src.tag) begin
        res.valid = 1'b1;
        res.value = ext_bus.value;
      end
    end
    return res;
  endfunction

endpackage
